// ==== project.f ====
logic/neuralPkg.sv
logic/neuronNode.sv
logic/denseLayer.sv
logic/argmaxSelect.sv
logic/netClassifier.sv
testbench/tbNetClassifier.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the classifier testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tbNetClassifier \
	-f project.f \
	--Mdir build \
	-o simNetClassifier

./build/simNetClassifier | tee sim.log

if grep -q "=== PASS ===" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// ==== testbench/tbNetClassifier.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbNetClassifier;

	import neuralPkg::*;

	localparam int resetCycles = 10;
	localparam int postResetIdle = 7;
	localparam int isolatedCount = 40;
	localparam int maxGap = 8;
	localparam int directedCount = 4;
	localparam int directedGap = 8;
	localparam int streamCount = 200;
	localparam int settleCycles = 10;
	localparam int pipeLatency = 7;
	localparam int vectorTotal = isolatedCount + directedCount + streamCount;
	localparam int gapTotal = postResetIdle + isolatedCount * maxGap
		+ directedCount * directedGap + settleCycles;
	localparam int cycleLimit = resetCycles + vectorTotal + gapTotal + 50;

	typedef struct packed {
		int dueCycle;
		scoreVector scores;
		classifyResult result;
	} expectEntry;

	logic clk = 1'b0;
	logic reset;
	logic inStrobe;
	featureVector features;
	logic outStrobe;
	classifyResult result;
	scoreVector scores;

	expectEntry expectQueue[$];
	classifyResult lastResult = '0;
	scoreVector lastScores = '0;
	int cycle = 0;
	int inCount = 0;
	int outCount = 0;
	int valueErrors = 0;
	int timingErrors = 0;
	int otherErrors = 0;

	netClassifier netClassifier_i (
		.clk(clk),
		.reset(reset),
		.inStrobe(inStrobe),
		.features(features),
		.outStrobe(outStrobe),
		.result(result),
		.scores(scores)
	);

	always #20 clk = ~clk;

	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		if (cycle >= cycleLimit)
		begin
			$display("Timeout after %0d cycles with %0d results still pending", cycle,
				expectQueue.size());
			$display("=== FAIL ===");
			$finish;
		end
	end

	// Rectify, round half up on bit 5, then clamp
	function automatic int activate(input int sum);
		int scaled;
		if (sum < 0)
		begin
			return 0;
		end
		scaled = (sum >>> 6) + ((sum >>> 5) & 1);
		if (scaled > 127)
		begin
			scaled = 127;
		end
		return scaled;
	endfunction

	function automatic hiddenVector hiddenModel(input featureVector f);
		hiddenVector h;
		int sum;
		for (int n = 0; n < hiddenCount; n++)
		begin
			sum = int'($signed(hiddenBiases[n]));
			for (int i = 0; i < featureCount; i++)
			begin
				sum += int'($signed(hiddenWeights[n][i])) * int'($signed(f[i]));
			end
			h[n] = actValue'(activate(sum));
		end
		return h;
	endfunction

	function automatic scoreVector scoreModel(input hiddenVector h);
		scoreVector s;
		int sum;
		for (int c = 0; c < classCount; c++)
		begin
			sum = int'($signed(outputBiases[c]));
			for (int i = 0; i < hiddenCount; i++)
			begin
				sum += int'($signed(outputWeights[c][i])) * int'($signed(h[i]));
			end
			s[c] = actValue'(activate(sum));
		end
		return s;
	endfunction

	function automatic classifyResult pickClass(input scoreVector s);
		classifyResult r;
		r.classId = '0;
		r.score = s[0];
		for (int c = 1; c < classCount; c++)
		begin
			if ($signed(s[c]) > $signed(r.score))  // Ties keep the lower class
			begin
				r.classId = classIndex'(c);
				r.score = s[c];
			end
		end
		return r;
	endfunction

	function automatic featureVector randomVector();
		featureVector f;
		for (int i = 0; i < featureCount; i++)
		begin
			f[i] = actValue'($urandom);
		end
		return f;
	endfunction

	// Outputs only move on the rising edge
	task automatic checkOutputs();
		expectEntry e;
		if (outStrobe)
		begin
			outCount++;
			if (expectQueue.size() == 0)
			begin
				$display("Output strobe at %0t with no vector pending", $time);
				otherErrors++;
			end
			else
			begin
				e = expectQueue.pop_front();
				if (cycle != e.dueCycle)
				begin
					$display("FAIL t=%0t outStrobe cycle expected %0d got %0d", $time,
						e.dueCycle, cycle);
					timingErrors++;
				end
				if (scores !== e.scores)
				begin
					$display("FAIL t=%0t scores expected %h got %h", $time, e.scores, scores);
					valueErrors++;
				end
				if (result !== e.result)
				begin
					$display("FAIL t=%0t result expected %h got %h", $time, e.result, result);
					valueErrors++;
				end
				lastResult = e.result;
				lastScores = e.scores;
			end
		end
		else
		begin
			if (result !== lastResult)
			begin
				$display("FAIL t=%0t result expected %h got %h", $time, lastResult, result);
				valueErrors++;
			end
			if (scores !== lastScores)
			begin
				$display("FAIL t=%0t scores expected %h got %h", $time, lastScores, scores);
				valueErrors++;
			end
		end
	endtask

	task automatic idleCycle();
		@(negedge clk);
		checkOutputs();
		inStrobe = 1'b0;
	endtask

	task automatic sendVector(input featureVector f);
		expectEntry e;
		@(negedge clk);
		checkOutputs();
		features = f;
		inStrobe = 1'b1;
		e.dueCycle = cycle + pipeLatency;
		e.scores = scoreModel(hiddenModel(f));
		e.result = pickClass(e.scores);
		expectQueue.push_back(e);
		inCount++;
	endtask

	initial
	begin
		void'($urandom(32'h4ae6_68d6));
		reset = 1'b1;
		inStrobe = 1'b0;
		features = '0;
		repeat (resetCycles) idleCycle();
		reset = 1'b0;
		repeat (postResetIdle) idleCycle();

		for (int v = 0; v < isolatedCount; v++)
		begin
			sendVector(randomVector());
			repeat (1 + $urandom % maxGap) idleCycle();
		end

		sendVector({featureCount{8'h7f}});  // Positive full scale
		repeat (directedGap) idleCycle();
		sendVector({featureCount{8'h80}});
		repeat (directedGap) idleCycle();
		sendVector('0);  // All scores tie at zero
		repeat (directedGap) idleCycle();
		sendVector('0);
		repeat (directedGap) idleCycle();

		for (int v = 0; v < streamCount; v++)
		begin
			sendVector(randomVector());
		end

		while (expectQueue.size() != 0)
		begin
			idleCycle();
		end
		repeat (settleCycles) idleCycle();

		if (outCount != inCount)
		begin
			$display("Output count %0d does not match input count %0d", outCount, inCount);
			otherErrors++;
		end

		$display("Errors: value %0d, timing %0d, other %0d", valueErrors, timingErrors,
			otherErrors);
		if (valueErrors + timingErrors + otherErrors == 0)
		begin
			$display("=== PASS ===");
		end
		else
		begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== logic/netClassifier.sv ====
`timescale 1ns/1ps
`default_nettype none

module netClassifier (
	input logic clk,
	input logic reset,
	input logic inStrobe,
	input neuralPkg::featureVector features,
	output logic outStrobe,
	output neuralPkg::classifyResult result,
	output neuralPkg::scoreVector scores
);

	import neuralPkg::*;

	logic hiddenStrobe;
	hiddenVector hiddenActs;
	logic scoreStrobe;
	scoreVector rawScores;  // Unregistered by the selector

	denseLayer #(
		.fanIn(featureCount),
		.nodeCount(hiddenCount),
		.weights(hiddenWeights),
		.biases(hiddenBiases)
	) hiddenLayer_i (
		.clk(clk),
		.reset(reset),
		.inStrobe(inStrobe),
		.inVector(features),
		.outStrobe(hiddenStrobe),
		.outVector(hiddenActs)
	);

	denseLayer #(
		.fanIn(hiddenCount),
		.nodeCount(classCount),
		.weights(outputWeights),
		.biases(outputBiases)
	) outputLayer_i (
		.clk(clk),
		.reset(reset),
		.inStrobe(hiddenStrobe),
		.inVector(hiddenActs),
		.outStrobe(scoreStrobe),
		.outVector(rawScores)
	);

	argmaxSelect argmaxSelect_i (
		.clk(clk),
		.reset(reset),
		.inStrobe(scoreStrobe),
		.inScores(rawScores),
		.outStrobe(outStrobe),
		.result(result),
		.scores(scores)
	);

endmodule

`default_nettype wire

// ==== logic/argmaxSelect.sv ====
`timescale 1ns/1ps
`default_nettype none

module argmaxSelect (
	input logic clk,
	input logic reset,
	input logic inStrobe,
	input neuralPkg::scoreVector inScores,
	output logic outStrobe,
	output neuralPkg::classifyResult result,
	output neuralPkg::scoreVector scores
);

	import neuralPkg::*;

	classifyResult best;

	always_comb
	begin
		best.classId = '0;
		best.score = inScores[0];
		for (int i = 1; i < classCount; i++)
		begin
			if ($signed(inScores[i]) > $signed(best.score))  // Strict, lowest index wins ties
			begin
				best.classId = classIndex'(i);
				best.score = inScores[i];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			outStrobe <= 1'b0;
			result <= '0;
			scores <= '0;
		end
		else
		begin
			outStrobe <= inStrobe;
			if (inStrobe)
			begin
				result <= best;  // Held until the next strobe
				scores <= inScores;
			end
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		outStrobe |-> (result.classId < classCount));

endmodule

`default_nettype wire

// ==== logic/denseLayer.sv ====
`timescale 1ns/1ps
`default_nettype none

module denseLayer #(
	parameter int fanIn = neuralPkg::featureCount,
	parameter int nodeCount = neuralPkg::hiddenCount,
	parameter neuralPkg::weightValue [nodeCount-1:0][fanIn-1:0] weights = '0,
	parameter neuralPkg::biasValue [nodeCount-1:0] biases = '0
) (
	input logic clk,
	input logic reset,
	input logic inStrobe,
	input neuralPkg::actValue [fanIn-1:0] inVector,
	output logic outStrobe,
	output neuralPkg::actValue [nodeCount-1:0] outVector
);

	import neuralPkg::*;

	logic [neuronLatency-1:0] strobePipe;

	// Every neuron sees the same vector, each with its own weight row
	genvar node;
	generate
		for (node = 0; node < nodeCount; node++)
		begin : gNode
			neuronNode #(
				.fanIn(fanIn),
				.weights(weights[node]),
				.bias(biases[node])
			) neuronNode_i (
				.clk(clk),
				.reset(reset),
				.inputs(inVector),
				.activation(outVector[node])
			);
		end
	endgenerate

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			strobePipe <= '0;
		end
		else
		begin
			strobePipe <= {strobePipe[neuronLatency-2:0], inStrobe};
		end
	end

	assign outStrobe = strobePipe[neuronLatency-1];  // Tracks neuron latency

	assert property (@(posedge clk) disable iff (reset)
		outStrobe == $past(inStrobe, neuronLatency));

endmodule

`default_nettype wire

// ==== logic/neuronNode.sv ====
`timescale 1ns/1ps
`default_nettype none

module neuronNode #(
	parameter int fanIn = neuralPkg::featureCount,
	parameter neuralPkg::weightValue [fanIn-1:0] weights = '0,
	parameter neuralPkg::biasValue bias = '0
) (
	input logic clk,
	input logic reset,
	input neuralPkg::actValue [fanIn-1:0] inputs,
	output neuralPkg::actValue activation
);

	import neuralPkg::*;

	actValue [fanIn-1:0] inputReg;  // Stage 1
	accumValue sumReg;  // Stage 2
	logic signed [actWidth+weightWidth-1:0] products [fanIn];
	accumValue sumNext;
	accumValue scaled;
	accumValue rounded;
	actValue actNext;

	// Full precision products, sign extended before the adder tree
	always_comb
	begin
		for (int i = 0; i < fanIn; i++)
		begin
			products[i] = $signed(inputReg[i]) * $signed(weights[i]);
		end
	end

	always_comb
	begin
		sumNext = accumValue'(bias);
		for (int i = 0; i < fanIn; i++)
		begin
			sumNext = sumNext + accumValue'(products[i]);
		end
	end

	assign scaled = sumReg >>> activationShift;
	assign rounded = scaled + accumValue'(sumReg[activationShift-1]);  // Round half up

	always_comb
	begin
		if (sumReg[accumWidth-1])
		begin
			actNext = '0;  // Rectify
		end
		else if (rounded > accumValue'(actMax))
		begin
			actNext = actValue'(actMax);  // Clamp after rounding
		end
		else
		begin
			actNext = actValue'(rounded);
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inputReg <= '0;
			sumReg <= '0;
			activation <= '0;
		end
		else
		begin
			inputReg <= inputs;
			sumReg <= sumNext;
			activation <= actNext;
		end
	end

	assert property (@(posedge clk) disable iff (reset) activation >= 0);

endmodule

`default_nettype wire

// ==== logic/neuralPkg.sv ====
`default_nettype none

package neuralPkg;

	localparam int actWidth = 8;
	localparam int weightWidth = 8;
	localparam int biasWidth = 16;
	localparam int accumWidth = 23;  // Room for 15 full products plus bias
	localparam int classWidth = 2;

	localparam int featureCount = 15;
	localparam int hiddenCount = 6;
	localparam int classCount = 3;

	localparam int neuronLatency = 3;  // Input, sum and activation registers
	localparam int activationShift = 6;  // Sum carries 6 fraction bits
	localparam int actMax = 127;

	typedef logic signed [actWidth-1:0] actValue;
	typedef logic signed [weightWidth-1:0] weightValue;
	typedef logic signed [biasWidth-1:0] biasValue;
	typedef logic signed [accumWidth-1:0] accumValue;
	typedef logic [classWidth-1:0] classIndex;

	typedef actValue [featureCount-1:0] featureVector;
	typedef actValue [hiddenCount-1:0] hiddenVector;
	typedef actValue [classCount-1:0] scoreVector;

	typedef struct packed {
		classIndex classId;
		actValue score;
	} classifyResult;

	typedef weightValue [hiddenCount-1:0][featureCount-1:0] hiddenWeightTable;
	typedef biasValue [hiddenCount-1:0] hiddenBiasTable;
	typedef weightValue [classCount-1:0][hiddenCount-1:0] outputWeightTable;
	typedef biasValue [classCount-1:0] outputBiasTable;

	// Rows run from the highest neuron down, and within a row the
	// leftmost weight belongs to the highest input index
	localparam hiddenWeightTable hiddenWeights = '{
		'{-8'sd15, 8'sd22, 8'sd20, -8'sd30, 8'sd13, -8'sd6, 8'sd25, 8'sd4,
			8'sd11, -8'sd21, -8'sd9, 8'sd15, 8'sd27, -8'sd3, -8'sd12},  // Neuron 5
		'{8'sd14, -8'sd8, 8'sd6, 8'sd12, -8'sd28, 8'sd31, 8'sd18, 8'sd7,
			-8'sd23, 8'sd2, 8'sd24, -8'sd16, -8'sd10, 8'sd29, 8'sd5},  // Neuron 4
		'{-8'sd2, 8'sd17, -8'sd29, 8'sd23, 8'sd8, -8'sd13, -8'sd4, 8'sd26,
			8'sd19, -8'sd11, 8'sd1, 8'sd30, -8'sd18, 8'sd10, -8'sd25},  // Neuron 3
		'{8'sd4, -8'sd19, 8'sd24, -8'sd1, 8'sd16, 8'sd7, -8'sd30, 8'sd13,
			-8'sd6, 8'sd28, -8'sd22, 8'sd9, 8'sd3, -8'sd14, 8'sd21},  // Neuron 2
		'{-8'sd17, 8'sd5, 8'sd11, -8'sd26, -8'sd9, 8'sd14, 8'sd2, -8'sd20,
			8'sd31, 8'sd6, -8'sd12, -8'sd3, 8'sd25, 8'sd18, -8'sd7},  // Neuron 1
		'{8'sd20, 8'sd8, -8'sd31, 8'sd10, 8'sd22, -8'sd27, 8'sd15, -8'sd8,
			8'sd9, -8'sd15, 8'sd27, -8'sd31, -8'sd5, 8'sd4, 8'sd12}  // Neuron 0
	};

	localparam hiddenBiasTable hiddenBiases = '{
		-16'sd320, -16'sd64, 16'sd0, -16'sd128, -16'sd256, -16'sd512
	};

	localparam outputWeightTable outputWeights = '{
		'{-8'sd24, 8'sd17, 8'sd9, -8'sd20, 8'sd12, 8'sd15},  // Class 2
		'{8'sd13, -8'sd19, 8'sd27, 8'sd6, 8'sd22, -8'sd11},  // Class 1
		'{8'sd7, 8'sd30, -8'sd14, 8'sd25, -8'sd9, 8'sd18}  // Class 0
	};

	// Non-positive so a zero vector ties every class at 0
	localparam outputBiasTable outputBiases = '{
		-16'sd100, -16'sd48, 16'sd0
	};

endpackage

`default_nettype wire
